//--- list.f
verilog/jpeg_mcu_pkg.sv
verilog/dp_ram_be.sv
verilog/raster_counter.sv
verilog/chroma_subsampler.sv
verilog/mcu_buffer.sv
verilog/jpeg_mcu_frontend.sv
test/tb_jpeg_mcu_frontend.sv

//--- Bender.yml
package:
  name: jpeg_mcu_frontend

sources:
  - verilog/jpeg_mcu_pkg.sv
  - verilog/dp_ram_be.sv
  - verilog/raster_counter.sv
  - verilog/chroma_subsampler.sv
  - verilog/mcu_buffer.sv
  - verilog/jpeg_mcu_frontend.sv
  - target: test
    files:
      - test/tb_jpeg_mcu_frontend.sv

//--- test/mcu_input.hex
// line 1 x_size_m1 y_size_m1, next 8 lines one input line each, pixels as {y,cb,cr}
// last 6 lines expected rows of Y0 Y1 Y2 Y3 Cb Cr, rows 0..7, sample 0 in the low byte
07 07
607090 61718f 62728e 63738d 64748c 65758b 66768a 677789
68748c 69758b 6a768a 6b7789 6c7888 6d7987 6e7a86 6f7b85
707888 717987 727a86 737b85 747c84 757d83 767e82 777f81
787c84 797d83 7a7e82 7b7f81 7c8080 7d817f 7e827e 7f837d
808080 81817f 82827e 83837d 84847c 85857b 86867a 878779
88847c 89857b 8a867a 8b8779 8c8878 8d8977 8e8a76 8f8b75
908878 918977 928a76 938b75 948c74 958d73 968e72 978f71
988c74 998d73 9a8e72 9b8f71 9c9070 9d916f 9e926e 9f936d
e7e6e5e4e3e2e1e0 efeeedecebeae9e8 f7f6f5f4f3f2f1f0 fffefdfcfbfaf9f8 0706050403020100 0f0e0d0c0b0a0908 1716151413121110 1f1e1d1c1b1a1918
0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1f1e1d1c1b1a1918 1f1e1d1c1b1a1918 1f1e1d1c1b1a1918 1f1e1d1c1b1a1918 1f1e1d1c1b1a1918 1f1e1d1c1b1a1918 1f1e1d1c1b1a1918 1f1e1d1c1b1a1918
0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000
f7f7f7f7f7f5f3f1 fffffffffffdfbf9 0707070707050301 0f0f0f0f0f0d0b09 0f0f0f0f0f0d0b09 0f0f0f0f0f0d0b09 0f0f0f0f0f0d0b09 0f0f0f0f0f0d0b09
0a0a0a0a0a0c0e10 0202020202040608 fafafafafafcfe00 f2f2f2f2f2f4f6f8 f2f2f2f2f2f4f6f8 f2f2f2f2f2f4f6f8 f2f2f2f2f2f4f6f8 f2f2f2f2f2f4f6f8

//--- test/tb_jpeg_mcu_frontend.sv
`default_nettype none

module tb_jpeg_mcu_frontend import jpeg_mcu_pkg::*; ();

    localparam int SENSOR_X_SIZE = 64;
    localparam int SENSOR_Y_SIZE = 64;
    localparam int XW            = $clog2(SENSOR_X_SIZE);
    localparam int YW            = $clog2(SENSOR_Y_SIZE);

    localparam int PERIOD        = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int FRAMES        = 2;
    localparam int FRAME_PIXELS  = 64;
    localparam int FRAME_ROWS    = 48;
    // 4 cycles per pixel or row is a generous worst case
    localparam int WATCHDOG_TIME = FRAMES * (FRAME_PIXELS + FRAME_ROWS) * 4 * PERIOD + 2000;
    localparam int unsigned SEED = 32'h2834_ad9e;

    // word offsets in the data file
    localparam int PIX_BASE   = 2;
    localparam int EXP_BASE   = PIX_BASE + FRAME_PIXELS;
    localparam int FILE_WORDS = EXP_BASE + FRAME_ROWS;

    logic          clk;
    logic          resetn;
    ycbcr_t        pix;
    logic          pix_valid;
    logic          pix_hold;
    logic [XW-1:0] x_size_m1;
    logic [YW-1:0] y_size_m1;
    mcu_row_t      row;
    logic          row_valid;
    logic          row_hold;
    logic [2:0]    row_idx;

    logic [63:0] vec_mem [FILE_WORDS];

    int          data_errors;
    int          index_errors;
    int          hold_errors;
    int          reset_errors;
    int          rows_seen;
    int unsigned rnd;

    jpeg_mcu_frontend #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) jpeg_mcu_frontend_inst (
        .clk         (clk),
        .resetn      (resetn),
        .pix_i       (pix),
        .pix_valid_i (pix_valid),
        .pix_hold_o  (pix_hold),
        .x_size_m1_i (x_size_m1),
        .y_size_m1_i (y_size_m1),
        .row_o       (row),
        .row_valid_o (row_valid),
        .row_hold_i  (row_hold),
        .row_idx_o   (row_idx)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // run length bound
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: only %0d of %0d rows arrived within %0d time units",
                 rows_seen, FRAMES * FRAME_ROWS, WATCHDOG_TIME);
        $display("TEST FAIL");
        $finish;
    end

    function automatic string block_name(input int blk);
        case (blk)
            0: return "Y0";
            1: return "Y1";
            2: return "Y2";
            3: return "Y3";
            4: return "Cb";
            default: return "Cr";
        endcase
    endfunction

    // no back-pressure and no rows while in or just out of reset
    task automatic check_idle_outputs();
        if (pix_hold !== 1'b0 || row_valid !== 1'b0) begin
            reset_errors++;
            $display("Fail at time %0t: pix_hold_o %b row_valid_o %b, both expected low",
                     $time, pix_hold, row_valid);
        end
    endtask

    // one pixel, with a random idle gap before it
    task automatic send_pixel(input ycbcr_t p);
        int gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(negedge clk);
            pix_valid = 1'b0;
        end
        @(negedge clk);
        pix       = p;
        pix_valid = 1'b1;
        // hold only moves on rising edges, so it is settled here
        while (pix_hold) begin
            @(negedge clk);
        end
    endtask

    task automatic feed_frames();
        for (int f = 0; f < FRAMES; f++) begin
            for (int i = 0; i < FRAME_PIXELS; i++) begin
                send_pixel(ycbcr_t'(vec_mem[PIX_BASE + i][23:0]));
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    // scoreboard, rows in Y0 Y1 Y2 Y3 Cb Cr order
    task automatic check_row(input mcu_row_t got, input logic [2:0] got_idx);
        int          k;
        int          frame;
        int          blk;
        int          r;
        logic [63:0] expected;
        k        = rows_seen % FRAME_ROWS;
        frame    = rows_seen / FRAME_ROWS;
        blk      = k / 8;
        r        = k % 8;
        expected = vec_mem[EXP_BASE + k];
        if (got !== expected) begin
            data_errors++;
            $display("Fail at time %0t: frame %0d block %s row %0d expected %h got %h",
                     $time, frame, block_name(blk), r, expected, got);
        end
        if (got_idx !== 3'(r)) begin
            index_errors++;
            $display("Fail at time %0t: frame %0d block %s row index expected %0d got %0d",
                     $time, frame, block_name(blk), r, got_idx);
        end
        rows_seen++;
    endtask

    task automatic collect_rows();
        logic       hold;
        logic       prev_valid;
        logic       prev_hold;
        mcu_row_t   prev_row;
        logic [2:0] prev_idx;
        prev_valid = 1'b0;
        prev_hold  = 1'b0;
        prev_row   = '0;
        prev_idx   = '0;
        while (rows_seen < FRAMES * FRAME_ROWS) begin
            @(negedge clk);
            // a stalled row must not move
            if (prev_valid && prev_hold) begin
                if (row_valid !== 1'b1 || row !== prev_row || row_idx !== prev_idx) begin
                    hold_errors++;
                    $display("Fail at time %0t: row changed under hold, expected %h got %h",
                             $time, prev_row, row);
                end
            end
            hold     = ($urandom % 3) == 0;
            row_hold = hold;
            // taken on the next rising edge
            if (row_valid && !hold) begin
                check_row(row, row_idx);
            end
            prev_valid = row_valid;
            prev_hold  = hold;
            prev_row   = row;
            prev_idx   = row_idx;
        end
        row_hold = 1'b0;
    endtask

    // nothing beyond the two frames
    task automatic check_no_extra_rows();
        repeat (20) begin
            @(negedge clk);
            if (row_valid !== 1'b0) begin
                index_errors++;
                $display("Fail at time %0t: extra row %h after the last frame", $time, row);
            end
        end
    endtask

    initial begin
        rnd          = $urandom(SEED);
        data_errors  = 0;
        index_errors = 0;
        hold_errors  = 0;
        reset_errors = 0;
        rows_seen    = 0;
        $readmemh("test/mcu_input.hex", vec_mem);
        x_size_m1 = vec_mem[0][XW-1:0];
        y_size_m1 = vec_mem[1][YW-1:0];
        pix       = '0;
        pix_valid = 1'b0;
        row_hold  = 1'b0;
        resetn    = 1'b0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs();
        end
        resetn = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end

        fork
            feed_frames();
            collect_rows();
        join
        check_no_extra_rows();

        $display("errors: data %0d, row index %0d, hold %0d, reset %0d",
                 data_errors, index_errors, hold_errors, reset_errors);
        if (data_errors + index_errors + hold_errors + reset_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/jpeg_mcu_frontend.sv
`default_nettype none

module jpeg_mcu_frontend import jpeg_mcu_pkg::*; #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720,
    localparam int XW           = $clog2(SENSOR_X_SIZE),
    localparam int YW           = $clog2(SENSOR_Y_SIZE)
) (
    input  wire logic          clk,
    input  wire logic          resetn,
    input  wire ycbcr_t        pix_i,
    input  wire logic          pix_valid_i,
    output logic               pix_hold_o,
    input  wire logic [XW-1:0] x_size_m1_i,
    input  wire logic [YW-1:0] y_size_m1_i,
    output mcu_row_t           row_o,
    output logic               row_valid_o,
    input  wire logic          row_hold_i,
    output logic      [2:0]    row_idx_o
);

    // raster position of the accepted pixel
    logic          accept;
    logic [XW-1:0] pixel_cnt;
    logic [YW-1:0] line_cnt;

    // subsampled beat into the buffer
    ycbcr_t        ycc;
    comp_valid_t   comp_valid;
    logic [XW-1:0] beat_pixel_cnt;
    logic [YW-1:0] beat_line_cnt;

    raster_counter #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) raster_counter_inst (
        .clk         (clk),
        .resetn      (resetn),
        .accept_i    (accept),
        .x_size_m1_i (x_size_m1_i),
        .y_size_m1_i (y_size_m1_i),
        .pixel_cnt_o (pixel_cnt),
        .line_cnt_o  (line_cnt)
    );

    chroma_subsampler #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) chroma_subsampler_inst (
        .clk          (clk),
        .resetn       (resetn),
        .pix_i        (pix_i),
        .pix_valid_i  (pix_valid_i),
        .hold_i       (pix_hold_o),
        .pixel_cnt_i  (pixel_cnt),
        .line_cnt_i   (line_cnt),
        .ycc_o        (ycc),
        .comp_valid_o (comp_valid),
        .pixel_cnt_o  (beat_pixel_cnt),
        .line_cnt_o   (beat_line_cnt),
        .accept_o     (accept)
    );

    // buffer full is the back-pressure to the source
    mcu_buffer #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) mcu_buffer_inst (
        .clk          (clk),
        .resetn       (resetn),
        .ycc_i        (ycc),
        .comp_valid_i (comp_valid),
        .pixel_cnt_i  (beat_pixel_cnt),
        .line_cnt_i   (beat_line_cnt),
        .hold_o       (pix_hold_o),
        .x_size_m1_i  (x_size_m1_i),
        .y_size_m1_i  (y_size_m1_i),
        .di_o         (row_o),
        .di_valid_o   (row_valid_o),
        .di_hold_i    (row_hold_i),
        .di_cnt_o     (row_idx_o)
    );

endmodule

`default_nettype wire

//--- verilog/mcu_buffer.sv
`default_nettype none

module mcu_buffer import jpeg_mcu_pkg::*; #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720,
    localparam int XW           = $clog2(SENSOR_X_SIZE),
    localparam int YW           = $clog2(SENSOR_Y_SIZE)
) (
    input  wire logic          clk,
    input  wire logic          resetn,
    input  wire ycbcr_t        ycc_i,
    input  wire comp_valid_t   comp_valid_i,
    input  wire logic [XW-1:0] pixel_cnt_i,
    input  wire logic [YW-1:0] line_cnt_i,
    output logic               hold_o,
    input  wire logic [XW-1:0] x_size_m1_i,
    input  wire logic [YW-1:0] y_size_m1_i,
    output mcu_row_t           di_o,
    output logic               di_valid_o,
    input  wire logic          di_hold_i,
    output logic      [2:0]    di_cnt_o
);

    // 16 luma lines x 2 halves, one 8-sample word per address
    localparam int LAW = XW + 2;
    // 8 chroma lines x 2 halves x cb/cr
    localparam int CAW = XW + 1;
    // 16-pixel block columns and 16-line stripes
    localparam int BCW = XW - 4;
    localparam int BVW = YW - 4;
    localparam int RW  = 8 * $bits(sample_t);

    typedef logic [XW-1:0]  xpos_t;
    typedef logic [YW-1:0]  ypos_t;
    typedef logic [2:0]     row_idx_t;
    typedef logic [BCW-1:0] blk_col_t;
    typedef logic [BVW-1:0] blk_row_t;

    // stripe FIFO pointers, two entries
    logic [1:0] wptr;
    logic [1:0] rptr;
    logic       full;
    logic       empty;
    logic       rd_go;

    assign empty  = (wptr == rptr);
    assign full   = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);
    assign hold_o = full;
    assign rd_go  = !di_hold_i && !empty;

    // stripe done on last pixel of line 15 or of the last frame line
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= '0;
        end else if (!full && comp_valid_i[0] && pixel_cnt_i == x_size_m1_i &&
                     (line_cnt_i[3:0] == 4'd15 || line_cnt_i == y_size_m1_i)) begin
            wptr <= wptr + 1'b1;
        end
    end

    // write side
    sample_t          y_wd;
    sample_t          c_wd;
    logic [LAW-1:0]   luma_wa;
    logic [CAW-1:0]   chroma_wa;
    logic [7:0]       luma_wbe;
    logic [7:0]       chroma_wbe;
    logic             luma_we;
    logic             chroma_we;

    assign y_wd = sample_t'(ycc_i.y - JPEG_BIAS);
    assign c_wd = sample_t'((comp_valid_i[2] ? ycc_i.cr : ycc_i.cb) - JPEG_BIAS);

    assign luma_wa = {pixel_cnt_i[XW-1:3], line_cnt_i[3:0], wptr[0]};
    // lsb picks cb or cr
    assign chroma_wa = {pixel_cnt_i[XW-1:4], line_cnt_i[3:1], wptr[0], comp_valid_i[2]};

    // last pixel of a line pads the rest of its word
    assign luma_wbe = ((pixel_cnt_i == x_size_m1_i) ? 8'hff : 8'h01) << pixel_cnt_i[2:0];
    assign chroma_wbe = ((pixel_cnt_i[XW-1:1] == x_size_m1_i[XW-1:1]) ? 8'hff : 8'h01)
                        << pixel_cnt_i[3:1];

    assign luma_we   = comp_valid_i[0] & ~full;
    assign chroma_we = (|comp_valid_i[2:1]) & ~full;

    // read side counters
    row_idx_t row_cnt;
    mcu_sel_t mcu_sel;
    blk_col_t blk_col;
    blk_row_t blk_row;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            row_cnt <= '0;
            mcu_sel <= Y0;
            blk_col <= '0;
            blk_row <= '0;
        end else if (rd_go) begin
            row_cnt <= row_cnt + 1'b1;
            if (row_cnt == 3'd7) begin
                if (mcu_sel == CR) begin
                    mcu_sel <= Y0;
                    if (blk_col == x_size_m1_i[XW-1:4]) begin
                        blk_col <= '0;
                        // next stripe, wraps with the frame
                        if (blk_row == y_size_m1_i[YW-1:4]) begin
                            blk_row <= '0;
                        end else begin
                            blk_row <= blk_row + 1'b1;
                        end
                    end else begin
                        blk_col <= blk_col + 1'b1;
                    end
                end else begin
                    mcu_sel <= mcu_sel_t'(mcu_sel + 3'd1);
                end
            end
        end
    end

    // release a stripe after its last cr row
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr <= '0;
        end else if (rd_go && row_cnt == 3'd7 && mcu_sel == CR &&
                     blk_col == x_size_m1_i[XW-1:4]) begin
            rptr <= rptr + 1'b1;
        end
    end

    // position of the current row in the frame
    xpos_t          r_x_luma;
    ypos_t          r_y_luma;
    ypos_t          r_y_chroma;
    logic           is_luma;
    logic           gray_x;
    logic [3:0]     luma_line;
    logic [2:0]     chroma_line;
    logic [LAW-1:0] luma_ra;
    logic [CAW-1:0] chroma_ra;
    logic           luma_re;
    logic           chroma_re;

    assign is_luma    = !mcu_sel[2];
    assign r_x_luma   = {blk_col, mcu_sel[0], 3'b000};
    assign r_y_luma   = {blk_row, mcu_sel[1], row_cnt};
    assign r_y_chroma = {1'b0, blk_row, row_cnt};

    // right of the image reads zero
    assign gray_x = r_x_luma[XW-1:3] > x_size_m1_i[XW-1:3];

    // below the image repeat the last line
    assign luma_line   = (r_y_luma > y_size_m1_i) ? y_size_m1_i[3:0] : {mcu_sel[1], row_cnt};
    assign chroma_line = (r_y_chroma > (y_size_m1_i >> 1)) ? y_size_m1_i[3:1] : row_cnt;

    assign luma_ra   = {blk_col, mcu_sel[0], luma_line, rptr[0]};
    assign chroma_ra = {blk_col, chroma_line, rptr[0], mcu_sel[0]};
    assign luma_re   = rd_go & is_luma;
    assign chroma_re = rd_go & ~is_luma;

    logic [RW-1:0] luma_rd;
    logic [RW-1:0] chroma_rd;

    dp_ram_be #(
        .DW    (RW),
        .DEPTH (2 ** LAW)
    ) luma_buf (
        .clk   (clk),
        .wa_i  (luma_wa),
        .wd_i  ({8{y_wd}}),
        .wbe_i (luma_wbe),
        .we_i  (luma_we),
        .ra_i  (luma_ra),
        .re_i  (luma_re),
        .rd_o  (luma_rd)
    );

    dp_ram_be #(
        .DW    (RW),
        .DEPTH (2 ** CAW)
    ) chroma_buf (
        .clk   (clk),
        .wa_i  (chroma_wa),
        .wd_i  ({8{c_wd}}),
        .wbe_i (chroma_wbe),
        .we_i  (chroma_we),
        .ra_i  (chroma_ra),
        .re_i  (chroma_re),
        .rd_o  (chroma_rd)
    );

    // output side, aligned with the RAM read register
    logic luma_q;
    logic gray_q;

    always_ff @(posedge clk) begin
        if (rd_go) begin
            luma_q   <= is_luma;
            di_cnt_o <= row_cnt;
        end
        if (luma_re) begin
            gray_q <= gray_x;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            di_valid_o <= 1'b0;
        end else if (!di_hold_i) begin
            di_valid_o <= !empty;
        end
    end

    assign di_o = luma_q ? (gray_q ? '0 : mcu_row_t'(luma_rd)) : mcu_row_t'(chroma_rd);

    // block grid needs odd size-minus-one
    a_odd_size: assert property (@(posedge clk) disable iff (!resetn)
        x_size_m1_i[0] && y_size_m1_i[0]);

endmodule

`default_nettype wire

//--- verilog/chroma_subsampler.sv
`default_nettype none

module chroma_subsampler import jpeg_mcu_pkg::*; #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720,
    localparam int XW           = $clog2(SENSOR_X_SIZE),
    localparam int YW           = $clog2(SENSOR_Y_SIZE)
) (
    input  wire logic          clk,
    input  wire logic          resetn,
    input  wire ycbcr_t        pix_i,
    input  wire logic          pix_valid_i,
    input  wire logic          hold_i,
    input  wire logic [XW-1:0] pixel_cnt_i,
    input  wire logic [YW-1:0] line_cnt_i,
    output ycbcr_t             ycc_o,
    output comp_valid_t        comp_valid_o,
    output logic      [XW-1:0] pixel_cnt_o,
    output logic      [YW-1:0] line_cnt_o,
    output logic               accept_o
);

    // rounded mean of two samples
    function automatic pixel_t pair_avg(input pixel_t a, input pixel_t b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b} + 9'd1;
        return sum[8:1];
    endfunction

    // even pixel, later odd pixel y plus cr average
    ycbcr_t          lat;
    // odd pixel beat waiting for its slot
    logic            pend;
    logic [XW-1:0]   pend_x;
    logic [YW-1:0]   pend_y;
    logic            odd_acc;
    pixel_t          cb_avg;
    pixel_t          cr_avg;

    assign accept_o = pix_valid_i & ~hold_i;
    assign odd_acc  = accept_o & pixel_cnt_i[0];
    assign cb_avg   = pair_avg(lat.cb, pix_i.cb);
    assign cr_avg   = pair_avg(lat.cr, pix_i.cr);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend <= 1'b0;
        end else begin
            // set by the odd pixel, always drained on the next cycle
            pend <= odd_acc;
        end
    end

    // pixel payload
    always_ff @(posedge clk) begin
        if (accept_o && !pixel_cnt_i[0]) begin
            lat <= pix_i;
        end else if (odd_acc) begin
            lat.y  <= pix_i.y;
            lat.cr <= cr_avg;
            pend_x <= pixel_cnt_i;
            pend_y <= line_cnt_i;
        end
    end

    always_comb begin
        ycc_o        = lat;
        comp_valid_o = '0;
        pixel_cnt_o  = pend_x;
        line_cnt_o   = pend_y;
        if (pend) begin
            // odd pixel with cr, chroma only on even lines
            comp_valid_o = {~pend_y[0], 1'b0, 1'b1};
        end else if (odd_acc) begin
            // even pixel with cb
            ycc_o.cb     = cb_avg;
            comp_valid_o = {1'b0, ~line_cnt_i[0], 1'b1};
            pixel_cnt_o  = {pixel_cnt_i[XW-1:1], 1'b0};
            line_cnt_o   = line_cnt_i;
        end
    end

    // buffer fills only after the cr beat of a strip's last pixel
    a_pend_no_hold: assert property (@(posedge clk) disable iff (!resetn)
        pend |-> !hold_i);

endmodule

`default_nettype wire

//--- verilog/raster_counter.sv
`default_nettype none

module raster_counter #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720,
    localparam int XW           = $clog2(SENSOR_X_SIZE),
    localparam int YW           = $clog2(SENSOR_Y_SIZE)
) (
    input  wire logic          clk,
    input  wire logic          resetn,
    input  wire logic          accept_i,
    input  wire logic [XW-1:0] x_size_m1_i,
    input  wire logic [YW-1:0] y_size_m1_i,
    output logic      [XW-1:0] pixel_cnt_o,
    output logic      [YW-1:0] line_cnt_o
);

    typedef logic [XW-1:0] xpos_t;
    typedef logic [YW-1:0] ypos_t;

    // position of the next pixel to be accepted
    xpos_t x_q;
    ypos_t y_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            x_q <= '0;
            y_q <= '0;
        end else if (accept_i) begin
            if (x_q == x_size_m1_i) begin
                // end of line
                x_q <= '0;
                if (y_q == y_size_m1_i) begin
                    // last line, next pixel opens a new frame
                    y_q <= '0;
                end else begin
                    y_q <= y_q + 1'b1;
                end
            end else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    // valid in the same cycle as the accepted pixel
    assign pixel_cnt_o = x_q;
    assign line_cnt_o  = y_q;

    // frame must fit the line buffers
    a_x_size: assert property (@(posedge clk) disable iff (!resetn)
        x_size_m1_i < SENSOR_X_SIZE);
    a_y_size: assert property (@(posedge clk) disable iff (!resetn)
        y_size_m1_i < SENSOR_Y_SIZE);

endmodule

`default_nettype wire

//--- verilog/dp_ram_be.sv
`default_nettype none

module dp_ram_be #(
    parameter int DW    = 64,
    parameter int DEPTH = 256,
    localparam int AW   = $clog2(DEPTH),
    localparam int BW   = DW / 8
) (
    input  wire logic          clk,
    input  wire logic [AW-1:0] wa_i,
    input  wire logic [DW-1:0] wd_i,
    input  wire logic [BW-1:0] wbe_i,
    input  wire logic          we_i,
    input  wire logic [AW-1:0] ra_i,
    input  wire logic          re_i,
    output logic      [DW-1:0] rd_o
);

    logic [DW-1:0] mem [DEPTH];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < BW; i++) begin
                if (wbe_i[i]) begin
                    mem[wa_i][i*8 +: 8] <= wd_i[i*8 +: 8];
                end
            end
        end
    end

    // registered read, holds while re_i is low
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i];
        end
    end

    // both ports stay inside the array
    a_wa_range: assert property (@(posedge clk) we_i |-> (wa_i < DEPTH));
    a_ra_range: assert property (@(posedge clk) re_i |-> (ra_i < DEPTH));

endmodule

`default_nettype wire

//--- verilog/jpeg_mcu_pkg.sv
`default_nettype none

package jpeg_mcu_pkg;

    // sample width is fixed, the 64-bit RAM row holds eight of them
    localparam int SAMPLE_W = 8;

    // unsigned component sample as it comes from the sensor pipe
    typedef logic [SAMPLE_W-1:0] pixel_t;

    // level-shifted sample, DCT input range -128..127
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // one 4:4:4 pixel
    typedef struct packed {
        pixel_t y;
        pixel_t cb;
        pixel_t cr;
    } ycbcr_t;

    // per component valid, bit 0 y, bit 1 cb, bit 2 cr
    typedef logic [2:0] comp_valid_t;

    // one row of an 8x8 block, element 0 is the leftmost sample
    typedef sample_t [7:0] mcu_row_t;

    // block order inside a 4:2:0 MCU
    typedef enum logic [2:0] {Y0, Y1, Y2, Y3, CB, CR} mcu_sel_t;

    // JPEG level shift
    localparam pixel_t JPEG_BIAS = 8'd128;

endpackage

`default_nettype wire
